// File: Makefile
SOURCES := $(shell grep -v '^+' sim.f)

.PHONY: run clean

run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu 2>&1 | tee sim.log
	@! grep -q "Done: errors found" sim.log
	@grep -q "Done: no errors" sim.log

obj_dir/Vtb_cpu: sim.f $(SOURCES) verification/program_input.txt
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
		-f sim.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

// File: hdl/alu.sv
`timescale 1ns/1ns

module alu (
    input  rv_pkg::word_t     a,
    input  rv_pkg::word_t     b,
    input  rv_pkg::alu_ctrl_t alu_control,
    output rv_pkg::word_t     result,
    output logic              zero
);

    logic signed_less;
    logic unsigned_less;

    assign signed_less   = $signed(a) < $signed(b);
    assign unsigned_less = a < b;

    always_comb begin
        case (alu_control)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_and:  result = a & b;
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_slt:  result = {{(rv_pkg::xlen-1){1'b0}}, signed_less};
            rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, unsigned_less};
            default:          result = a + b; // Unused codes add
        endcase
    end

    // beq relies on this after a subtract
    assign zero = (result == '0);

endmodule

// File: hdl/control.sv
`timescale 1ns/1ns

module control (
    input  logic [6:0]       op,
    input  logic [2:0]       func3,
    input  logic [6:0]       func7,
    input  logic             alu_zero,
    output rv_pkg::alu_ctrl_t alu_control,
    output rv_pkg::imm_src_t  imm_source,
    output logic             mem_write,
    output logic             reg_write,
    output logic             alu_source,
    output rv_pkg::wb_src_t   write_back_source,
    output logic             pc_source,
    output logic             second_add_source
);

    logic [1:0] alu_op;     // 00 mem, 01 branch, 10 reg, 11 imm
    logic       branch;
    logic       jump;
    logic       reg_write_dec;
    logic       mem_write_dec;
    logic       check_func; // Opcode carries a real funct3
    logic       func_ok;
    logic       legal;

    // Main decoder
    always_comb begin
        reg_write_dec     = 1'b0;
        mem_write_dec     = 1'b0;
        imm_source        = rv_pkg::imm_i;
        alu_source        = 1'b0;
        write_back_source = rv_pkg::wb_alu;
        alu_op            = 2'b00;
        branch            = 1'b0;
        jump              = 1'b0;
        second_add_source = 1'b0;
        check_func        = 1'b1;
        case (op)
            rv_pkg::op_load: begin
                reg_write_dec     = 1'b1;
                alu_source        = 1'b1;
                write_back_source = rv_pkg::wb_mem;
            end
            rv_pkg::op_alu_imm: begin
                reg_write_dec = 1'b1;
                alu_source    = 1'b1;
                alu_op        = 2'b11;
            end
            rv_pkg::op_store: begin
                mem_write_dec = 1'b1;
                imm_source    = rv_pkg::imm_s;
                alu_source    = 1'b1; // Base plus offset
            end
            rv_pkg::op_alu_reg: begin
                reg_write_dec = 1'b1;
                alu_op        = 2'b10;
            end
            rv_pkg::op_branch: begin
                imm_source = rv_pkg::imm_b;
                alu_op     = 2'b01;
                branch     = 1'b1;
            end
            rv_pkg::op_jal: begin
                reg_write_dec     = 1'b1;
                imm_source        = rv_pkg::imm_j;
                write_back_source = rv_pkg::wb_pc4;
                jump              = 1'b1;
                check_func        = 1'b0;
            end
            rv_pkg::op_lui, rv_pkg::op_auipc: begin
                reg_write_dec     = 1'b1;
                imm_source        = rv_pkg::imm_u;
                write_back_source = rv_pkg::wb_upper;
                second_add_source = op[5]; // Zero base for lui
                check_func        = 1'b0;
            end
            default: begin
                // Unknown opcode leaves state alone
                reg_write_dec = 1'b0;
                mem_write_dec = 1'b0;
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        alu_control = rv_pkg::alu_add;
        func_ok     = 1'b0;
        case (alu_op)
            2'b00: func_ok = (func3 == 3'b010);   // lw / sw only
            2'b01: begin
                alu_control = rv_pkg::alu_sub;
                func_ok     = (func3 == 3'b000);  // beq only
            end
            default: begin
                case (func3)
                    3'b000: begin
                        if (!alu_op[0]) begin
                            alu_control = func7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                            func_ok     = ((func7 & 7'b1011111) == 7'b0);
                        end else begin
                            func_ok = 1'b1; // addi
                        end
                    end
                    3'b111: begin
                        alu_control = rv_pkg::alu_and;
                        func_ok     = alu_op[0] | (func7 == 7'b0);
                    end
                    3'b110: begin
                        alu_control = rv_pkg::alu_or;
                        func_ok     = alu_op[0] | (func7 == 7'b0);
                    end
                    3'b010: begin
                        alu_control = rv_pkg::alu_slt;
                        func_ok     = alu_op[0] | (func7 == 7'b0);
                    end
                    3'b011: begin
                        alu_control = rv_pkg::alu_sltu;
                        func_ok     = alu_op[0] | (func7 == 7'b0);
                    end
                    default: func_ok = 1'b0; // Shifts, xor
                endcase
            end
        endcase
    end

    assign legal     = ~check_func | func_ok;
    assign reg_write = reg_write_dec & legal;
    assign mem_write = mem_write_dec & legal;
    assign pc_source = (alu_zero & branch & legal) | jump;

endmodule

// File: hdl/cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic          clk,
    input  logic          arst_n,
    input  rv_pkg::word_t instr,
    input  rv_pkg::word_t mem_rdata,
    output rv_pkg::word_t instr_addr,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic          mem_write
);

    rv_pkg::instr_u    inst;
    rv_pkg::word_t     pc;
    rv_pkg::word_t     pc_next;
    rv_pkg::word_t     pc_plus4;
    rv_pkg::word_t     pc_target;
    rv_pkg::word_t     imm_ext;
    rv_pkg::word_t     reg_data1;
    rv_pkg::word_t     reg_data2;
    rv_pkg::word_t     src_b;
    rv_pkg::word_t     alu_result;
    rv_pkg::word_t     upper_base;
    rv_pkg::word_t     upper_result;
    rv_pkg::word_t     write_back_data;

    rv_pkg::alu_ctrl_t alu_control;
    rv_pkg::imm_src_t  imm_source;
    rv_pkg::wb_src_t   write_back_source;
    logic              store_dec;
    logic              reg_write;
    logic              alu_source;
    logic              pc_source;
    logic              second_add_source;
    logic              alu_zero;

    assign inst = instr;

    control ctrl0 (
        .op                (inst.r.opcode),
        .func3             (inst.r.funct3),
        .func7             (inst.r.funct7),
        .alu_zero          (alu_zero),
        .alu_control       (alu_control),
        .imm_source        (imm_source),
        .mem_write         (store_dec),
        .reg_write         (reg_write),
        .alu_source        (alu_source),
        .write_back_source (write_back_source),
        .pc_source         (pc_source),
        .second_add_source (second_add_source)
    );

    // PC register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4   = pc + 32'd4;
    assign pc_target  = pc + imm_ext;   // Branch and jal target
    assign pc_next    = pc_source ? pc_target : pc_plus4;
    assign instr_addr = pc;

    // Immediate generator
    always_comb begin
        case (imm_source)
            rv_pkg::imm_i: imm_ext = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            rv_pkg::imm_s: imm_ext = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5,
                                      inst.s.imm_4_0};
            rv_pkg::imm_b: imm_ext = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                                      inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            rv_pkg::imm_j: imm_ext = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                                      inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            rv_pkg::imm_u: imm_ext = {inst.u.imm_31_12, 12'b0};
            default:       imm_ext = '0;
        endcase
    end

    regfile rf0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .read_addr1   (inst.r.rs1),
        .read_addr2   (inst.r.rs2),
        .write_addr   (inst.r.rd),
        .write_enable (reg_write & arst_n), // Held off during reset
        .write_data   (write_back_data),
        .read_data1   (reg_data1),
        .read_data2   (reg_data2)
    );

    assign src_b = alu_source ? imm_ext : reg_data2;

    alu alu0 (
        .a           (reg_data1),
        .b           (src_b),
        .alu_control (alu_control),
        .result      (alu_result),
        .zero        (alu_zero)
    );

    // lui adds to zero, auipc to its own PC
    assign upper_base   = second_add_source ? '0 : pc;
    assign upper_result = upper_base + imm_ext;

    always_comb begin
        case (write_back_source)
            rv_pkg::wb_alu:   write_back_data = alu_result;
            rv_pkg::wb_mem:   write_back_data = mem_rdata;
            rv_pkg::wb_pc4:   write_back_data = pc_plus4;
            rv_pkg::wb_upper: write_back_data = upper_result;
            default:          write_back_data = alu_result;
        endcase
    end

    // Data port
    assign mem_addr  = alu_result;
    assign mem_wdata = reg_data2;
    assign mem_write = store_dec & arst_n;

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic          clk,
    input  logic          arst_n,
    input  logic [4:0]    read_addr1,
    input  logic [4:0]    read_addr2,
    input  logic [4:0]    write_addr,
    input  logic          write_enable,
    input  rv_pkg::word_t write_data,
    output rv_pkg::word_t read_data1,
    output rv_pkg::word_t read_data2
);

    // x1..x31 only, x0 has no storage
    rv_pkg::word_t regs [31:1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && (write_addr != 5'd0)) begin
            regs[write_addr] <= write_data;
        end
    end

    assign read_data1 = (read_addr1 == 5'd0) ? '0 : regs[read_addr1];
    assign read_data2 = (read_addr2 == 5'd0) ? '0 : regs[read_addr2];

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [2:0] alu_ctrl_t;
    typedef logic [2:0] imm_src_t;
    typedef logic [1:0] wb_src_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_lui     = 7'b0110111; // Bit 5 set
    localparam logic [6:0] op_auipc   = 7'b0010111; // Bit 5 clear

    // ALU operations
    localparam alu_ctrl_t alu_add  = 3'b000;
    localparam alu_ctrl_t alu_sub  = 3'b001;
    localparam alu_ctrl_t alu_and  = 3'b010;
    localparam alu_ctrl_t alu_or   = 3'b011;
    localparam alu_ctrl_t alu_slt  = 3'b101;
    localparam alu_ctrl_t alu_sltu = 3'b111;

    // Immediate formats
    localparam imm_src_t imm_i = 3'b000;
    localparam imm_src_t imm_s = 3'b001;
    localparam imm_src_t imm_b = 3'b010;
    localparam imm_src_t imm_j = 3'b011;
    localparam imm_src_t imm_u = 3'b100;

    // Write-back sources
    localparam wb_src_t wb_alu   = 2'b00;
    localparam wb_src_t wb_mem   = 2'b01;
    localparam wb_src_t wb_pc4   = 2'b10;
    localparam wb_src_t wb_upper = 2'b11; // lui / auipc result

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // One instruction word, six ways to read it
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

endpackage

// File: sim.f
hdl/rv_pkg.sv
hdl/alu.sv
hdl/regfile.sv
hdl/control.sv
hdl/cpu.sv
verification/cpu_props.sv
verification/tb_cpu.sv

// File: verification/cpu_props.sv
`timescale 1ns/1ns

module cpu_props (
    input logic          clk,
    input logic          arst_n,
    input rv_pkg::word_t instr_addr,
    input logic          mem_write,
    input logic          reg_write,
    input logic          pc_source
);

    // No store can leak out of reset
    no_store_in_reset: assert property (@(posedge clk) !arst_n |-> !mem_write)
        else $error("mem_write high while arst_n low");

    pc_aligned: assert property (@(posedge clk) instr_addr[1:0] == 2'b00)
        else $error("instr_addr 0x%08h not word aligned", instr_addr);

    // Sequential fetch unless a taken beq or a jal redirects
    pc_step: assert property (@(posedge clk) disable iff (!arst_n)
        (instr_addr != $past(instr_addr)) |->
            ((instr_addr == $past(instr_addr) + 32'd4) || $past(pc_source)))
        else $error("instr_addr jumped to 0x%08h without pc_source", instr_addr);

    store_or_writeback: assert property (@(posedge clk) !(mem_write && reg_write))
        else $error("mem_write and reg_write high together");

endmodule

bind cpu cpu_props props0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .instr_addr (instr_addr),
    .mem_write  (mem_write),
    .reg_write  (reg_write),
    .pc_source  (pc_source)
);

// File: verification/program_input.txt
// Program word count, then instruction words; store count, then address and data pairs
// Last word is the PC where the closing jal-to-self halts
00000028
01300093 ffa00113 002081b3 40208233 // addi x1 19, addi x2 -6, add x3, sub x4
0020f2b3 0020e333 00e0f393 0400e413 // and x5, or x6, andi x7, ori x8
0020a4b3 0020b533 00112593 00113613 // slt x9, sltu x10, slti x11, sltiu x12
10302023 10402223 10502423 10602623 // sw x3..x6 to 0x100..0x10c
10702823 10802a23 10902c23 10a02e23 // sw x7..x10 to 0x110..0x11c
12b02023 12c02223 10002683 00700013 // sw x11, sw x12, lw x13 from 0x100, addi x0
12d02423 12002623 00108463 12102823 // sw x13, sw x0, beq x1 x1 taken, skipped sw
00208463 12202823 0080076f 12102a23 // beq x1 x2 not taken, sw x2, jal x14, skipped sw
12e02a23 123457b7 00001817 12f02c23 // sw x14, lui x15, auipc x16 at 0x88, sw x15
13002e23 0010008b 14102023 0000006f // sw x16, unknown opcode on x1, sw x1, halt
00000011
00000100 0000000d // add
00000104 00000019 // sub
00000108 00000012 // and
0000010c fffffffb // or
00000110 00000002 // andi
00000114 00000053 // ori
00000118 00000000 // slt, 19 vs -6
0000011c 00000001 // sltu, same operands
00000120 00000001 // slti
00000124 00000000 // sltiu
00000128 0000000d // lw copy of 0x100
0000012c 00000000 // x0 after write attempt
00000130 fffffffa // beq not taken
00000134 0000007c // jal link value
00000138 12345000 // lui
0000013c 00001088 // auipc
00000140 00000013 // x1 untouched by unknown opcode
0000009c

// File: verification/tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;

    localparam int imem_words  = 64;   // Fetch index is instr_addr[7:2]
    localparam int dmem_words  = 256;  // Data index is mem_addr[9:2]
    localparam int stim_words  = 128;
    localparam int halt_cycles = 4;
    localparam int max_cycles  = 2000;
    localparam rv_pkg::word_t reset_pc = 32'h0000_0000;

    logic          clk;
    logic          arst_n;
    rv_pkg::word_t instr;
    rv_pkg::word_t mem_rdata;
    rv_pkg::word_t instr_addr;
    rv_pkg::word_t mem_addr;
    rv_pkg::word_t mem_wdata;
    logic          mem_write;

    rv_pkg::word_t imem [0:imem_words-1];
    rv_pkg::word_t dmem [0:dmem_words-1];
    rv_pkg::word_t stim [0:stim_words-1]; // Raw words of the data file
    rv_pkg::word_t store_addr_q [$];
    rv_pkg::word_t store_data_q [$];
    rv_pkg::word_t halt_pc;

    cpu dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .mem_rdata  (mem_rdata),
        .instr_addr (instr_addr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_write  (mem_write)
    );

    // Both memories answer within the cycle
    assign instr     = imem[instr_addr[7:2]];
    assign mem_rdata = dmem[mem_addr[9:2]];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Data memory, cleared while the core is held in reset
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_write) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check_store(input rv_pkg::word_t got_addr, input rv_pkg::word_t got_data,
                               input rv_pkg::word_t want_addr, input rv_pkg::word_t want_data);
        if (got_addr !== want_addr) begin
            $display("ERR mem_addr: got 0x%08h, expected 0x%08h", got_addr, want_addr);
            abort_run();
        end else if (got_data !== want_data) begin
            $display("ERR mem_wdata at 0x%08h: got 0x%08h, expected 0x%08h",
                     got_addr, got_data, want_data);
            abort_run();
        end
    endtask

    task automatic check_pc(input rv_pkg::word_t got, input rv_pkg::word_t want);
        if (got !== want) begin
            $display("ERR instr_addr: got 0x%08h, expected 0x%08h", got, want);
            abort_run();
        end
    endtask

    // Mid-cycle look at each store, before the edge that commits it
    always @(negedge clk) begin
        if (arst_n && mem_write) begin
            if (store_addr_q.size() == 0) begin
                $display("Unexpected store of 0x%08h to 0x%08h", mem_wdata, mem_addr);
                abort_run();
            end else begin
                check_store(mem_addr, mem_wdata, store_addr_q.pop_front(),
                            store_data_q.pop_front());
            end
        end
    end

    initial begin
        int            n_prog;
        int            n_store;
        int            steady;
        int            cycles;
        rv_pkg::word_t last_pc;

        arst_n = 1'b0;
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = '0; // Opcode 0 is unknown, stray fetches only advance
        end
        $readmemh("verification/program_input.txt", stim);
        n_prog = int'(stim[0]);
        for (int i = 0; i < n_prog; i++) begin
            imem[i] = stim[i + 1];
        end
        n_store = int'(stim[n_prog + 1]);
        for (int k = 0; k < n_store; k++) begin
            store_addr_q.push_back(stim[n_prog + 2 + 2 * k]);
            store_data_q.push_back(stim[n_prog + 3 + 2 * k]);
        end
        halt_pc = stim[n_prog + 2 + 2 * n_store];

        repeat (16) @(posedge clk);
        check_pc(instr_addr, reset_pc);
        #2 arst_n = 1'b1;

        // Run until the closing jal-to-self pins the PC
        last_pc = instr_addr;
        steady  = 0;
        cycles  = 0;
        while (steady < halt_cycles) begin
            @(negedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                $display("Timeout: PC still moving after %0d cycles", max_cycles);
                abort_run();
            end else if (instr_addr == last_pc) begin
                steady++;
            end else begin
                steady  = 0;
                last_pc = instr_addr;
            end
        end

        check_pc(instr_addr, halt_pc);
        if (store_addr_q.size() != 0) begin
            $display("Missing stores: %0d expected stores never happened",
                     store_addr_q.size());
            abort_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
